// ==== ahb_to_apb_bridge.sv ====
`timescale 1ns/1ps

module ahb_to_apb_bridge
  import apb_subsys_pkg::*;
(
  input  logic     hclk,
  input  logic     rst_n,
  input  logic     hsel,        // Slave select from AHB decoder
  input  addr_t    haddr,
  input  htrans_t  htrans,
  input  logic     hwrite,
  input  data_t    hwdata,      // Valid in data phase
  input  logic     hready,      // Bus-wide ready
  output data_t    hrdata,
  output logic     hreadyout,
  output logic     hresp,       // OKAY=0, ERROR=1
  output logic     apb_active,  // High while a transfer is in flight
  apb_if.master    apb
);

  bridge_state_t state_q;
  bridge_state_t state_d;

  addr_t  addr_q;    // Latched address phase
  logic   write_q;
  data_t  wdata_q;   // Write data, taken in SETUP
  logic   accept;

  // NONSEQ or SEQ only, BUSY and IDLE are ignored
  assign accept = hsel & hready & htrans[1];

  // --------------------
  // State register
  always_ff @(posedge hclk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (accept) state_d = SETUP;    // No overlap with a pending transfer
      SETUP:    state_d = ACCESS;               // Always one cycle
      ACCESS:
      begin
        if (apb.pready)                         // Else hold, slave back-pressure
          state_d = apb.pslverr ? ERR1 : IDLE;
      end
      ERR1:     state_d = ERR2;
      ERR2:     state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  // --------------------
  // Payload capture
  always_ff @(posedge hclk)
  begin
    if (state_q == IDLE && accept)
    begin
      addr_q  <= haddr;                         // Address phase
      write_q <= hwrite;
    end
    if (state_q == SETUP)
      wdata_q <= hwdata;                        // First data-phase cycle
    if (state_q == ACCESS && apb.pready)
      hrdata  <= apb.prdata;                    // Read data back to AHB
  end

  // --------------------
  // APB side
  assign apb.psel    = (state_q == SETUP) || (state_q == ACCESS);
  assign apb.penable = (state_q == ACCESS);
  assign apb.pwrite  = write_q;
  assign apb.paddr   = addr_q;
  assign apb.pwdata  = (state_q == SETUP) ? hwdata : wdata_q;  // Same value, master holds hwdata

  // AHB response
  assign hreadyout  = (state_q == IDLE) || (state_q == ERR2);
  assign hresp      = (state_q == ERR1) || (state_q == ERR2); // Two-cycle error
  assign apb_active = (state_q != IDLE);

endmodule

// ==== apb_if.sv ====
`timescale 1ns/1ps

interface apb_if
  import apb_subsys_pkg::*;
();

  logic   psel;     // Slave select
  logic   penable;  // Access phase
  logic   pwrite;   // Write when high
  addr_t  paddr;    // Held stable through the transfer
  data_t  pwdata;   // Write data
  data_t  prdata;   // Read data from slave
  logic   pready;   // Slave ends the access
  logic   pslverr;  // Slave error, valid with pready

  // Bridge or mux output side
  modport master (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  // Mux input side or timer
  modport slave (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface

// ==== apb_slave_mux.sv ====
`timescale 1ns/1ps

`include "apb_subsys_params.svh"

module apb_slave_mux
  import apb_subsys_pkg::*;
(
  apb_if.slave   bus,   // From bridge
  apb_if.master  t0,    // Timer 0
  apb_if.master  t1     // Timer 1
);

  slot_t slot;
  logic  hit0;
  logic  hit1;

  assign slot = bus.paddr[`SLOT_MSB:`SLOT_LSB];
  assign hit0 = (slot == slot_t'(`TIMER0_SLOT));
  assign hit1 = (slot == slot_t'(`TIMER1_SLOT));

  // --------------------
  // Forward path, only psel is gated
  assign t0.psel    = bus.psel & hit0;
  assign t0.penable = bus.penable;
  assign t0.pwrite  = bus.pwrite;
  assign t0.paddr   = bus.paddr;
  assign t0.pwdata  = bus.pwdata;

  assign t1.psel    = bus.psel & hit1;
  assign t1.penable = bus.penable;
  assign t1.pwrite  = bus.pwrite;
  assign t1.paddr   = bus.paddr;
  assign t1.pwdata  = bus.pwdata;

  // --------------------
  // Return path
  always_comb
  begin
    if (hit0)
    begin
      bus.prdata  = t0.prdata;
      bus.pready  = t0.pready;
      bus.pslverr = t0.pslverr;
    end
    else if (hit1)
    begin
      bus.prdata  = t1.prdata;
      bus.pready  = t1.pready;
      bus.pslverr = t1.pslverr;
    end
    else
    begin
      bus.prdata  = '0;    // Unmapped slot
      bus.pready  = 1'b1;  // Answer at once
      bus.pslverr = 1'b1;  // Turned into AHB ERROR by the bridge
    end
  end

endmodule

// ==== apb_subsys_params.svh ====
`ifndef APB_SUBSYS_PARAMS_SVH
`define APB_SUBSYS_PARAMS_SVH

// Bus widths
`define APB_ADDR_W      16
`define APB_DATA_W      32

// Slot decode and peripheral map
`define SLOT_MSB        15
`define SLOT_LSB        12
`define NUM_TIMERS      2
`define TIMER0_SLOT     0
`define TIMER1_SLOT     1

// Timer register word offsets, PADDR[3:2]
`define REG_CTRL        2'd0
`define REG_VALUE       2'd1
`define REG_RELOAD      2'd2
`define REG_INTSTAT     2'd3

`define CTRL_EN_BIT     0
`define CTRL_IRQEN_BIT  3

`define SYNC_STAGES     2

`endif

// ==== apb_subsys_pkg.sv ====
package apb_subsys_pkg;

  `include "apb_subsys_params.svh"

  // --------------------
  // Bus types
  typedef logic [`APB_ADDR_W-1:0]         addr_t;     // Byte address on AHB and APB
  typedef logic [`APB_DATA_W-1:0]         data_t;     // Read and write data
  typedef logic [`SLOT_MSB-`SLOT_LSB:0]   slot_t;     // Peripheral slot number
  typedef logic [1:0]                     reg_off_t;  // Word offset inside a slot
  typedef logic [1:0]                     htrans_t;   // IDLE/BUSY/NONSEQ/SEQ

  // One bit per timer
  typedef logic [`NUM_TIMERS-1:0]         irq_vec_t;

  // --------------------
  // Bridge FSM
  typedef enum logic [2:0] {
    IDLE,     // Waiting for an AHB address phase
    SETUP,    // APB setup, psel only
    ACCESS,   // APB access, wait for pready
    ERR1,     // First error cycle, hreadyout low
    ERR2      // Second error cycle, hreadyout high
  } bridge_state_t;

endpackage

// ==== apb_subsystem.sv ====
`timescale 1ns/1ps

module apb_subsystem
  import apb_subsys_pkg::*;
(
  input  logic     hclk,
  input  logic     rst_n,
  input  logic     hsel,
  input  addr_t    haddr,
  input  htrans_t  htrans,
  input  logic     hwrite,
  input  data_t    hwdata,
  input  logic     hready,
  output data_t    hrdata,
  output logic     hreadyout,
  output logic     hresp,
  output logic     apb_active,
  output irq_vec_t irq         // Synchronized timer interrupts
);

  // --------------------
  // Internal buses
  apb_if bus_if ();            // Bridge to mux
  apb_if t0_if ();             // Mux to timer 0
  apb_if t1_if ();             // Mux to timer 1

  irq_vec_t timer_irq;         // Raw, before synchronizer

  ahb_to_apb_bridge u_bridge (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .hreadyout  (hreadyout),
    .hresp      (hresp),
    .apb_active (apb_active),
    .apb        (bus_if.master)
  );

  apb_slave_mux u_mux (
    .bus (bus_if.slave),
    .t0  (t0_if.master),
    .t1  (t1_if.master)
  );

  // Slot 0
  apb_timer u_timer0 (
    .hclk  (hclk),
    .rst_n (rst_n),
    .apb   (t0_if.slave),
    .irq   (timer_irq[0])
  );

  // Slot 1
  apb_timer u_timer1 (
    .hclk  (hclk),
    .rst_n (rst_n),
    .apb   (t1_if.slave),
    .irq   (timer_irq[1])
  );

  irq_sync_bank u_irq_sync (
    .hclk    (hclk),
    .rst_n   (rst_n),
    .irq_in  (timer_irq),
    .irq_out (irq)
  );

endmodule

// ==== apb_subsystem_assertions.sv ====
`timescale 1ns/1ps

module apb_subsystem_assertions
  import apb_subsys_pkg::*;
(
  input  logic     hclk,
  input  logic     rst_n,
  input  logic     hsel,
  input  logic     hready,
  input  htrans_t  htrans,
  input  logic     hreadyout,
  input  logic     hresp,
  input  logic     apb_active
);

  int unsigned err_cnt = 0;           // Failed assertions so far

  // Error response, hreadyout low then high
  a_err_pattern: assert property (@(posedge hclk) disable iff (!rst_n)
    $rose(hresp) |-> !hreadyout ##1 (hresp && hreadyout))
  else
  begin
    $error("hresp rose without the two-cycle error pattern");
    err_cnt++;
  end

  // Bridge stays idle until a transfer is accepted
  a_idle_hold: assert property (@(posedge hclk) disable iff (!rst_n)
    (!apb_active && !(hsel && hready && htrans[1])) |=> !apb_active)
  else
  begin
    $error("apb_active rose without an accepted transfer");
    err_cnt++;
  end

  // No wait states from an idle bridge
  a_idle_ready: assert property (@(posedge hclk) disable iff (!rst_n)
    !apb_active |-> hreadyout)
  else
  begin
    $error("hreadyout low while the bridge is idle");
    err_cnt++;
  end

endmodule

// ==== apb_subsystem_trace.txt ====
# op addr data expected ; W write, R read and compare, E unmapped slot (data 1 write, 0 read)
# I waits up to data cycles for irq[addr] to equal expected
W 0008 00000005 00000000
R 0008 00000000 00000005
W 0004 12345678 00000000
R 0004 00000000 12345678
W 1008 00000007 00000000
W 1000 00000002 00000000
R 1000 00000000 00000002
R 1008 00000000 00000007
R 0008 00000000 00000005
R 0004 00000000 12345678
E 2000 00000001 00000000
R 0008 00000000 00000005
E 3004 00000000 00000000
W 0004 00000005 00000000
W 0000 00000009 00000000
R 0000 00000000 00000009
I 0000 0000001e 00000001
R 000c 00000000 00000001
W 1004 00000003 00000000
W 1000 00000001 00000000
W 0000 00000000 00000000
W 000c 00000001 00000000
I 0000 00000014 00000000
R 000c 00000000 00000000
R 100c 00000000 00000000
I 0001 00000014 00000000

// ==== apb_timer.sv ====
`timescale 1ns/1ps

`include "apb_subsys_params.svh"

module apb_timer
  import apb_subsys_pkg::*;
(
  input  logic  hclk,
  input  logic  rst_n,
  apb_if.slave  apb,
  output logic  irq      // Level that follows INTSTAT
);

  logic [3:0] ctrl_q;    // [0] enable, [3] irq enable
  data_t      value_q;   // Current count
  data_t      reload_q;
  logic       intstat_q;

  reg_off_t   off;
  logic       in_range;  // Upper offset bits zero
  logic       wr_en;
  logic       tick_zero;

  assign off       = apb.paddr[3:2];
  assign in_range  = (apb.paddr[`SLOT_LSB-1:4] == '0);
  assign wr_en     = apb.psel & apb.penable & apb.pwrite & in_range;  // Access-cycle edge
  assign tick_zero = ctrl_q[`CTRL_EN_BIT] && (value_q == '0);

  // --------------------
  // Registers and counter
  always_ff @(posedge hclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl_q    <= '0;
      value_q   <= '0;
      reload_q  <= '0;
      intstat_q <= 1'b0;
    end
    else
    begin
      // Count down unless a software write below overrides
      if (tick_zero)
        value_q <= reload_q;                      // Wrap to reload
      else if (ctrl_q[`CTRL_EN_BIT])
        value_q <= value_q - data_t'(1);

      if (wr_en)
      begin
        case (off)
          `REG_CTRL:    ctrl_q   <= apb.pwdata[3:0];
          `REG_VALUE:   value_q  <= apb.pwdata;
          `REG_RELOAD:  reload_q <= apb.pwdata;
          `REG_INTSTAT: if (apb.pwdata[0]) intstat_q <= 1'b0;  // Write one to clear
          default:      ;
        endcase
      end

      // Set after clear so a same-cycle event is kept
      if (tick_zero && ctrl_q[`CTRL_IRQEN_BIT])
        intstat_q <= 1'b1;
    end
  end

  // --------------------
  // Read-back
  always_comb
  begin
    apb.prdata = '0;                              // Out-of-range offsets read zero
    if (in_range)
    begin
      case (off)
        `REG_CTRL:    apb.prdata = data_t'(ctrl_q);
        `REG_VALUE:   apb.prdata = value_q;
        `REG_RELOAD:  apb.prdata = reload_q;
        `REG_INTSTAT: apb.prdata = data_t'(intstat_q);
        default:      apb.prdata = '0;
      endcase
    end
  end

  assign apb.pready  = 1'b1;   // Zero wait states
  assign apb.pslverr = 1'b0;
  assign irq         = intstat_q;

endmodule

// ==== irq_sync_bank.sv ====
`timescale 1ns/1ps

`include "apb_subsys_params.svh"

module irq_sync_bank
  import apb_subsys_pkg::*;
#(
  parameter int WIDTH = `NUM_TIMERS   // Bits in irq_vec_t
) (
  input  logic      hclk,
  input  logic      rst_n,
  input  irq_vec_t  irq_in,    // From peripherals
  output irq_vec_t  irq_out    // Bus clock domain
);

  for (genvar i = 0; i < WIDTH; i++)
  begin : g_sync
    logic [`SYNC_STAGES-1:0] chain_q;   // Stage 0 samples the input

    always_ff @(posedge hclk or negedge rst_n)
    begin
      if (!rst_n)
        chain_q <= '0;
      else
        chain_q <= {chain_q[`SYNC_STAGES-2:0], irq_in[i]};
    end

    assign irq_out[i] = chain_q[`SYNC_STAGES-1];  // SYNC_STAGES cycles late
  end

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_apb_subsystem -o sim_tb || exit 1
out=$(./obj_dir/sim_tb +verilator+error+limit+100 2>&1)
echo "$out"
echo "$out" | grep -q "^Verification passed$" && exit 0 || exit 1

// ==== tb_apb_subsystem.sv ====
`timescale 1ns/1ps

module tb_apb_subsystem
  import apb_subsys_pkg::*;
();

  localparam int MAX_OPS       = 64;
  localparam int CYCLES_PER_OP = 40;            // Timeout budget per trace line

  logic      hclk;
  logic      rst_n;
  logic      hsel;
  addr_t     haddr;
  htrans_t   htrans;
  logic      hwrite;
  data_t     hwdata;
  logic      hready;
  data_t     hrdata;
  logic      hreadyout;
  logic      hresp;
  logic      apb_active;
  irq_vec_t  irq;

  logic [7:0] op_mem   [MAX_OPS];             // W, R, E or I
  addr_t      addr_mem [MAX_OPS];
  data_t      data_mem [MAX_OPS];
  data_t      exp_mem  [MAX_OPS];
  int         n_ops       = 0;
  int         cycle_cnt   = 0;
  int         cycle_limit = 0;                  // Zero until the trace is loaded
  int         pass_cnt    = 0;
  int         fail_cnt    = 0;

  assign hready = hreadyout;                    // Only slave on this AHB

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(3)) u_clk (
    .hclk  (hclk),
    .rst_n (rst_n)
  );

  apb_subsystem dut_i (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .hsel       (hsel),
    .haddr      (haddr),
    .htrans     (htrans),
    .hwrite     (hwrite),
    .hwdata     (hwdata),
    .hready     (hready),
    .hrdata     (hrdata),
    .hreadyout  (hreadyout),
    .hresp      (hresp),
    .apb_active (apb_active),
    .irq        (irq)
  );

  bind apb_subsystem apb_subsystem_assertions u_assertions (
    .hclk       (hclk),
    .rst_n      (rst_n),
    .hsel       (hsel),
    .hready     (hready),
    .htrans     (htrans),
    .hreadyout  (hreadyout),
    .hresp      (hresp),
    .apb_active (apb_active)
  );

  // --------------------
  // Watchdog
  always @(posedge hclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the trace did not finish", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic load_trace();
    int         fd;
    int         code;
    string      line;
    logic [7:0] op;
    addr_t      a;
    data_t      d;
    data_t      e;
    fd = $fopen("apb_subsystem_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open apb_subsystem_trace.txt");
    end
    else
    begin
      while (!$feof(fd) && n_ops < MAX_OPS)
      begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#")   // Skip comments and blanks
        begin
          code = $sscanf(line, "%s %h %h %h", op, a, d, e);
          if (code == 4)
          begin
            op_mem[n_ops]   = op;
            addr_mem[n_ops] = a;
            data_mem[n_ops] = d;
            exp_mem[n_ops]  = e;
            n_ops++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One AHB transfer that returns after the data phase with hreadyout high
  task automatic ahb_transfer(input addr_t a, input logic wr, input data_t wd,
                              output data_t rd, output logic err, output logic act_ok);
    logic idle_before;
    logic seen_active;
    @(posedge hclk);
    #1;
    idle_before = !apb_active;                  // Bus idle between transfers
    hsel   = 1'b1;
    haddr  = a;
    htrans = 2'b10;                             // NONSEQ
    hwrite = wr;
    @(posedge hclk);                            // Address phase accepted
    #1;
    hsel        = 1'b0;
    htrans      = 2'b00;
    hwdata      = wd;
    seen_active = apb_active;
    err         = hresp;
    while (!hreadyout)
    begin
      @(posedge hclk);
      #1;
      seen_active |= apb_active;
      err         |= hresp;
    end
    rd     = hrdata;
    act_ok = idle_before && seen_active;
  endtask

  task automatic show_mismatch(input string name, input data_t got, input data_t exp);
    $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
  endtask

  task automatic run_op(input int i);
    logic  ok;
    data_t rd;
    logic  err;
    logic  act_ok;
    int    waited;
    int    bit_i;
    ok    = 1'b1;
    bit_i = int'(addr_mem[i][0]);
    case (op_mem[i])
      "W", "R", "E":
      begin
        if (op_mem[i] == "E")
          ahb_transfer(addr_mem[i], data_mem[i][0], '0, rd, err, act_ok);
        else
          ahb_transfer(addr_mem[i], op_mem[i] == "W", data_mem[i], rd, err, act_ok);
        if (err !== (op_mem[i] == "E"))
        begin
          show_mismatch("hresp", data_t'(err), data_t'(op_mem[i] == "E"));
          ok = 1'b0;
        end
        if (op_mem[i] == "R" && rd !== exp_mem[i])
        begin
          show_mismatch("hrdata", rd, exp_mem[i]);
          ok = 1'b0;
        end
        if (!act_ok)
        begin
          $display("apb_active was not low before or high during the transfer");
          ok = 1'b0;
        end
      end
      "I":
      begin
        waited = 0;                             // Bounded wait for the level
        while (irq[bit_i] !== exp_mem[i][0] && waited < int'(data_mem[i]))
        begin
          @(posedge hclk);
          #1;
          waited++;
        end
        if (irq[bit_i] !== exp_mem[i][0])
        begin
          show_mismatch($sformatf("irq[%0d]", bit_i), data_t'(irq[bit_i]), exp_mem[i]);
          ok = 1'b0;
        end
      end
      default:
      begin
        $display("Unknown opcode on trace line %0d", i);
        ok = 1'b0;
      end
    endcase
    if (ok)
      pass_cnt++;
    else
      fail_cnt++;
    $display("test %0d %s %h: %s", i, op_mem[i], addr_mem[i], ok ? "PASS" : "FAIL");
  endtask

  // --------------------
  // Main sequence
  initial
  begin
    hsel   = 1'b0;
    haddr  = '0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hwdata = '0;
    load_trace();
    cycle_limit = CYCLES_PER_OP * n_ops + 10;   // Reset cycles on top
    wait (rst_n === 1'b1);
    for (int i = 0; i < n_ops; i++)
      run_op(i);
    $display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
             n_ops, pass_cnt, fail_cnt, dut_i.u_assertions.err_cnt);
    if (n_ops > 0 && fail_cnt == 0 && dut_i.u_assertions.err_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,   // Clock period
  parameter int RESET_CYCLES = 3     // Cycles with rst_n low
) (
  output logic hclk,
  output logic rst_n
);

  initial
  begin
    hclk = 1'b0;
    forever #(PERIOD_NS / 2) hclk = ~hclk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge hclk);
    #1 rst_n = 1'b1;                  // Release away from the edge
  end

endmodule

// ==== verilog.f ====
+incdir+.
apb_subsys_pkg.sv
apb_if.sv
ahb_to_apb_bridge.sv
apb_slave_mux.sv
apb_timer.sv
irq_sync_bank.sv
apb_subsystem.sv
apb_subsystem_assertions.sv
tb_clock_gen.sv
tb_apb_subsystem.sv
